// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f sim.f --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/lsu_properties.sv
`timescale 1ns/100ps

module lsu_properties (
    input logic                         clock,
    input logic                         reset_n,
    input logic                         tbus_index_valid,
    input logic                         tbus_index_ready,
    input logic [lsu_pkg::xlen-1:0]     tbus_index,
    input logic [lsu_pkg::xlen-1:0]     tbus_write_data,
    input logic [63:0]                  tbus_write_mask,
    input lsu_pkg::tbus_op_t            tbus_operation_type,
    input logic                         tbus_operation_done,
    input logic                         wb_valid
);

    logic fire;
    int   violations = 0;

    assign fire = tbus_index_valid && tbus_index_ready;

    // a request waiting for ready keeps all of its fields
    stable_while_waiting: assert property (@(posedge clock) disable iff (!reset_n)
        tbus_index_valid && !tbus_index_ready |=> tbus_index_valid
            && $stable(tbus_index) && $stable(tbus_write_data)
            && $stable(tbus_write_mask) && $stable(tbus_operation_type))
    else begin
        violations++;
        $error("bus request changed while waiting for ready");
    end

    // done pulses exactly ram_latency cycles after each fire and at no other time
    done_latency: assert property (@(posedge clock) disable iff (!reset_n)
        tbus_operation_done == $past(fire, lsu_pkg::ram_latency))
    else begin
        violations++;
        $error("bus done does not follow a fire by the memory latency");
    end

    single_cycle_wb: assert property (@(posedge clock) disable iff (!reset_n)
        wb_valid |=> !wb_valid)
    else begin
        violations++;
        $error("writeback valid held for two cycles");
    end

endmodule

bind lsu_bus_stage lsu_properties u_properties (
    .clock               (clock),
    .reset_n             (reset_n),
    .tbus_index_valid    (tbus_index_valid),
    .tbus_index_ready    (tbus_index_ready),
    .tbus_index          (tbus_index),
    .tbus_write_data     (tbus_write_data),
    .tbus_write_mask     (tbus_write_mask),
    .tbus_operation_type (tbus_operation_type),
    .tbus_operation_done (tbus_operation_done),
    .wb_valid            (wb_valid)
);

// File: bench/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;

    localparam int clock_period    = 8;
    localparam int directed_ops    = 71;
    localparam int random_ops      = 300;
    localparam int watchdog_cycles = (directed_ops + random_ops) * 20 + 200;

    logic                         clock;
    logic                         reset_n;
    logic                         instr_valid;
    lsu_pkg::issue_t              instr;
    logic                         instr_ready;
    logic                         flush_valid;
    logic [lsu_pkg::id_width-1:0] flush_id;
    logic                         wb_valid;
    lsu_pkg::wb_t                 wb;

    // byte image of the 4 KB that the data memory decodes
    logic [7:0]                   shadow [4096];
    lsu_pkg::wb_t                 expected_q [$];
    lsu_pkg::wb_t                 expected;
    logic [15:0]                  lfsr_state = 16'd47944;
    logic [lsu_pkg::id_width-1:0] next_id = '0;
    int                           cycle = 0;
    int                           accept_cycle = 0;
    int                           wb_cycle = 0;

    lsu_top u_dut (
        .clock       (clock),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .flush_valid (flush_valid),
        .flush_id    (flush_id),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] wanted);
        if (actual !== wanted) begin
            fail_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, actual, wanted));
        end
    endtask

    // galois lfsr x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits[i] = lfsr_state[0];
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    function automatic int size_bytes(input lsu_pkg::ls_size_t size);
        case (size)
            lsu_pkg::size_b: return 1;
            lsu_pkg::size_h: return 2;
            lsu_pkg::size_w: return 4;
            default:         return 8;
        endcase
    endfunction

    function automatic logic in_mmio(input logic [63:0] addr);
        return (addr >= lsu_pkg::mmio_low) && (addr <= lsu_pkg::mmio_high);
    endfunction

    // naturally aligned byte address inside the 4 KB space
    function automatic logic [63:0] random_addr(input int sel);
        return random_bits(12) & ~((64'd1 << sel) - 64'd1);
    endfunction

    function automatic lsu_pkg::wb_t reference_wb(input lsu_pkg::issue_t op);
        lsu_pkg::wb_t result;
        logic [63:0]  addr;
        logic [63:0]  value;
        int           nbytes;
        addr              = op.src1 + op.imm;
        nbytes            = size_bytes(op.ls_size);
        result.id         = op.id;
        result.prd        = op.prd;
        result.need_to_wb = op.is_load;
        result.mmio       = in_mmio(addr);
        result.data       = '0;
        if (op.is_load && !result.mmio) begin
            value = '0;
            // little endian, highest byte first into the accumulator
            for (int i = nbytes - 1; i >= 0; i--) begin
                value = (value << 8) | 64'(shadow[int'(addr[11:0]) + i]);
            end
            if (!op.is_unsigned && nbytes < 8 && value[nbytes * 8 - 1]) begin
                value = value | ~((64'd1 << (nbytes * 8)) - 64'd1);
            end
            result.data = value;
        end
        return result;
    endfunction

    function automatic void apply_store(input lsu_pkg::issue_t op);
        logic [63:0] addr;
        addr = op.src1 + op.imm;
        if (op.is_store && !in_mmio(addr)) begin
            for (int i = 0; i < size_bytes(op.ls_size); i++) begin
                shadow[int'(addr[11:0]) + i] = op.src2[i * 8 +: 8];
            end
        end
    endfunction

    function automatic lsu_pkg::issue_t make_op(input logic is_load, input int sel,
                                                input logic [63:0] addr,
                                                input logic [63:0] data,
                                                input logic is_unsigned);
        lsu_pkg::issue_t op;
        logic [63:0]     bits;
        op.id   = next_id;
        next_id = next_id + 1'b1;
        bits    = random_bits(lsu_pkg::preg_width);
        op.prd  = bits[lsu_pkg::preg_width-1:0];
        // part of the address comes from the immediate
        op.imm         = random_bits(11);
        op.src1        = addr - op.imm;
        op.src2        = data;
        op.is_load     = is_load;
        op.is_store    = !is_load;
        op.is_unsigned = is_unsigned;
        op.ls_size     = lsu_pkg::ls_size_t'(4'b0001 << sel);
        return op;
    endfunction

    // entered and left just after a falling edge
    task automatic issue_op(input lsu_pkg::issue_t op, input logic track);
        instr_valid = 1'b1;
        instr       = op;
        while (!instr_ready) begin
            @(negedge clock);
        end
        accept_cycle = cycle + 1;
        if (track) begin
            expected_q.push_back(reference_wb(op));
            apply_store(op);
        end
        @(negedge clock);
        instr_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (2) @(negedge clock);
    endtask

    always @(negedge clock) begin
        if (reset_n && wb_valid) begin
            if (expected_q.size() == 0) begin
                fail_run($sformatf("writeback for id %0d arrived with nothing pending", wb.id));
            end else begin
                wb_cycle = cycle;
                expected = expected_q.pop_front();
                check_value("wb id", 64'(wb.id), 64'(expected.id));
                check_value("wb prd", 64'(wb.prd), 64'(expected.prd));
                check_value("wb need_to_wb", 64'(wb.need_to_wb), 64'(expected.need_to_wb));
                check_value("wb mmio", 64'(wb.mmio), 64'(expected.mmio));
                check_value("wb data", wb.data, expected.data);
            end
        end
    end

    // the bound checker counts its assertion failures
    always @(u_dut.u_bus_stage.u_properties.violations) begin
        if (u_dut.u_bus_stage.u_properties.violations != 0) begin
            fail_run("a bus or writeback assertion failed");
        end
    end

    task automatic run_store_load_sweep();
        logic [63:0] base;
        for (int sel = 0; sel < 4; sel++) begin
            base = 64'h100 + 64'(sel * 16);
            issue_op(make_op(1'b0, 3, base, random_bits(64), 1'b0), 1'b1);
            for (int off = 0; off < 8; off += (1 << sel)) begin
                issue_op(make_op(1'b0, sel, base + 64'(off), random_bits(64), 1'b0), 1'b1);
            end
            // whole word shows how the partial stores merged
            issue_op(make_op(1'b1, 3, base, '0, 1'b0), 1'b1);
            for (int off = 0; off < 8; off += (1 << sel)) begin
                issue_op(make_op(1'b1, sel, base + 64'(off), '0, 1'b0), 1'b1);
                issue_op(make_op(1'b1, sel, base + 64'(off), '0, 1'b1), 1'b1);
            end
        end
        wait_drain();
    endtask

    task automatic run_back_to_back();
        int sel;
        for (int n = 0; n < 8; n++) begin
            sel = int'(random_bits(2));
            issue_op(make_op(1'b1, sel, random_addr(sel), '0, 1'b0), 1'b1);
        end
        wait_drain();
        issue_op(make_op(1'b1, 3, random_addr(3), '0, 1'b0), 1'b1);
        wait_drain();
        check_value("load latency in cycles", 64'(wb_cycle - accept_cycle), 64'd4);
    endtask

    task automatic run_mmio();
        issue_op(make_op(1'b0, 3, 64'h0, random_bits(64), 1'b0), 1'b1);
        // both would land on word 0 if they reached the memory
        issue_op(make_op(1'b0, 3, lsu_pkg::mmio_high, random_bits(64), 1'b0), 1'b1);
        issue_op(make_op(1'b0, 2, lsu_pkg::mmio_low, random_bits(64), 1'b0), 1'b1);
        wait_drain();
        issue_op(make_op(1'b1, 3, lsu_pkg::mmio_low, '0, 1'b0), 1'b1);
        wait_drain();
        check_value("mmio latency in cycles", 64'(wb_cycle - accept_cycle), 64'd2);
        issue_op(make_op(1'b1, 3, 64'h0, '0, 1'b0), 1'b1);
        issue_op(make_op(1'b1, 3, lsu_pkg::mmio_low - 64'h8, '0, 1'b0), 1'b1);
        issue_op(make_op(1'b1, 3, lsu_pkg::mmio_high + 64'h8, '0, 1'b0), 1'b1);
        wait_drain();
    endtask

    task automatic run_flush();
        lsu_pkg::issue_t op;
        // older flush id, the load is younger and must vanish
        op = make_op(1'b1, 3, random_addr(3), '0, 1'b0);
        issue_op(op, 1'b0);
        flush_valid = 1'b1;
        flush_id    = op.id - 8'd3;
        @(negedge clock);
        flush_valid = 1'b0;
        repeat (10) @(negedge clock);
        op = make_op(1'b1, 3, random_addr(3), '0, 1'b0);
        issue_op(op, 1'b1);
        flush_valid = 1'b1;
        flush_id    = op.id + 8'd3;
        @(negedge clock);
        flush_valid = 1'b0;
        wait_drain();
    endtask

    task automatic run_random_stream();
        logic [63:0] pick;
        logic [63:0] addr;
        int          sel;
        for (int n = 0; n < random_ops; n++) begin
            pick = random_bits(8);
            sel  = int'(pick[1:0]);
            if (pick[7:4] == 4'd0) begin
                addr = lsu_pkg::mmio_low + (random_bits(24) << 3);
            end else begin
                addr = random_addr(sel);
            end
            issue_op(make_op(pick[2], sel, addr, random_bits(64), pick[3]), 1'b1);
        end
        wait_drain();
    endtask

    initial begin
        reset_n     = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        flush_valid = 1'b0;
        flush_id    = '0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = 8'h00;
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        check_value("instr_ready after reset", 64'(instr_ready), 64'd1);
        run_store_load_sweep();
        run_back_to_back();
        run_mmio();
        run_flush();
        run_random_stream();
        if (u_dut.u_bus_stage.u_properties.violations == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run("bus or writeback assertions failed during the run");
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        fail_run($sformatf("timeout, the run did not finish in %0d cycles", watchdog_cycles));
    end

endmodule

// File: hdl/lsu_addr_stage.sv
`timescale 1ns/100ps

module lsu_addr_stage (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic                              instr_valid,
    input  lsu_pkg::issue_t                   instr,
    input  logic                              flush_valid,
    input  logic [lsu_pkg::id_width-1:0]      flush_id,
    input  logic                              req_ready,
    output logic                              instr_ready,
    output logic                              req_valid,
    output lsu_pkg::mem_req_t                 req
);

    logic [lsu_pkg::xlen-1:0] address;
    logic [2:0]               offset;
    logic                     mmio_hit;
    logic [63:0]              lane_mask;
    lsu_pkg::mem_req_t        next_req;
    logic                     accept;
    logic                     move;
    logic                     slot_flush;
    logic                     instr_flush;

    assign address  = instr.src1 + instr.imm;
    assign offset   = address[2:0];
    assign mmio_hit = (address >= lsu_pkg::mmio_low) && (address <= lsu_pkg::mmio_high);

    // byte lanes touched by a store, moved up to the byte offset
    always_comb begin
        case (instr.ls_size)
            lsu_pkg::size_b: lane_mask = {{56{1'b0}}, {8{1'b1}}} << {offset, 3'b000};
            lsu_pkg::size_h: lane_mask = {{48{1'b0}}, {16{1'b1}}} << {offset, 3'b000};
            lsu_pkg::size_w: lane_mask = {{32{1'b0}}, {32{1'b1}}} << {offset, 3'b000};
            default:         lane_mask = {64{1'b1}};
        endcase
    end

    always_comb begin
        next_req.id          = instr.id;
        next_req.prd         = instr.prd;
        next_req.address     = address;
        next_req.is_load     = instr.is_load;
        next_req.is_store    = instr.is_store;
        next_req.is_unsigned = instr.is_unsigned;
        next_req.ls_size     = instr.ls_size;
        next_req.mmio        = mmio_hit;
        next_req.write_data  = instr.src2 << {offset, 3'b000};
        next_req.write_mask  = lane_mask;
    end

    // one slot, refilled in the cycle it empties
    assign instr_ready = !req_valid || req_ready;
    assign accept      = instr_valid && instr_ready;
    assign move        = req_valid && req_ready;
    assign slot_flush  = flush_valid && lsu_pkg::older_than(flush_id, req.id);
    assign instr_flush = flush_valid && lsu_pkg::older_than(flush_id, instr.id);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            req_valid <= 1'b0;
        end else if (accept) begin
            req_valid <= !instr_flush;
        end else if (move || slot_flush) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req <= next_req;
        end
    end

endmodule

// File: hdl/lsu_bus_stage.sv
`timescale 1ns/100ps

module lsu_bus_stage (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          req_valid,
    input  lsu_pkg::mem_req_t             req,
    input  logic                          flush_valid,
    input  logic [lsu_pkg::id_width-1:0]  flush_id,
    input  logic                          tbus_index_ready,
    input  logic [lsu_pkg::xlen-1:0]      tbus_read_data,
    input  logic                          tbus_operation_done,
    output logic                          req_ready,
    output logic                          tbus_index_valid,
    output logic [lsu_pkg::xlen-1:0]      tbus_index,
    output logic [lsu_pkg::xlen-1:0]      tbus_write_data,
    output logic [63:0]                   tbus_write_mask,
    output lsu_pkg::tbus_op_t             tbus_operation_type,
    output logic                          wb_valid,
    output lsu_pkg::wb_t                  wb
);

    typedef enum logic [1:0] {
        st_idle,
        st_pending,
        st_outstanding
    } bus_state_t;

    bus_state_t               state;
    logic                     held;
    logic                     cancelled;
    lsu_pkg::mem_req_t        req_q;
    logic                     fire;
    logic                     bus_done;
    logic                     mmio_done;
    logic                     finish;
    logic                     held_flush;
    logic                     req_flush;
    logic                     take;
    logic [lsu_pkg::xlen-1:0] load_data;

    assign fire       = tbus_index_valid && tbus_index_ready;
    assign bus_done   = (state == st_outstanding) && tbus_operation_done;
    // an mmio result waits out a writeback already on the port,
    // so writebacks never run back to back
    assign mmio_done  = held && req_q.mmio && !wb_valid;
    assign finish     = bus_done || mmio_done;
    assign held_flush = flush_valid && held && lsu_pkg::older_than(flush_id, req_q.id);
    assign req_flush  = flush_valid && lsu_pkg::older_than(flush_id, req.id);

    // the slot frees up in the cycle its request finishes
    assign req_ready = !held || finish;
    assign take      = req_valid && req_ready && !req_flush;

    // bus fields come straight from the held request and stay put until the fire
    assign tbus_index_valid    = held && !req_q.mmio && (state != st_outstanding);
    assign tbus_index          = req_q.address;
    assign tbus_write_data     = req_q.write_data;
    assign tbus_write_mask     = req_q.write_mask;
    assign tbus_operation_type = req_q.is_store ? lsu_pkg::tbus_write : lsu_pkg::tbus_read;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= st_idle;
            held      <= 1'b0;
            cancelled <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            wb_valid <= finish && !cancelled && !held_flush;
            if (take) begin
                held      <= 1'b1;
                cancelled <= 1'b0;
                state     <= st_idle;
            end else if (finish || (held_flush && !fire && state != st_outstanding)) begin
                // done, or dropped by a flush before reaching the bus
                held  <= 1'b0;
                state <= st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        if (fire) begin
                            state <= st_outstanding;
                        end else if (tbus_index_valid) begin
                            state <= st_pending;
                        end
                    end
                    st_pending: begin
                        if (fire) begin
                            state <= st_outstanding;
                        end
                    end
                    st_outstanding: begin
                        if (tbus_operation_done) begin
                            state <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
                // already on the bus, so let it finish but drop the result
                if (held_flush && (fire || state == st_outstanding)) begin
                    cancelled <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            req_q <= req;
        end
    end

    lsu_load_align u_align (
        .tbus_read_data (tbus_read_data),
        .offset         (req_q.address[2:0]),
        .ls_size        (req_q.ls_size),
        .is_unsigned    (req_q.is_unsigned),
        .load_data      (load_data)
    );

    always_ff @(posedge clock) begin
        if (finish) begin
            wb.id         <= req_q.id;
            wb.prd        <= req_q.prd;
            wb.need_to_wb <= req_q.is_load;
            wb.mmio       <= req_q.mmio;
            wb.data       <= (req_q.is_load && !req_q.mmio) ? load_data : '0;
        end
    end

endmodule

// File: hdl/lsu_data_ram.sv
`timescale 1ns/100ps

module lsu_data_ram (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     tbus_index_valid,
    input  logic [lsu_pkg::xlen-1:0] tbus_index,
    input  logic [lsu_pkg::xlen-1:0] tbus_write_data,
    input  logic [63:0]              tbus_write_mask,
    input  lsu_pkg::tbus_op_t        tbus_operation_type,
    output logic                     tbus_index_ready,
    output logic [lsu_pkg::xlen-1:0] tbus_read_data,
    output logic                     tbus_operation_done
);

    logic [lsu_pkg::xlen-1:0]            mem [lsu_pkg::ram_words];
    logic [lsu_pkg::ram_index_width-1:0] word_index;
    logic [lsu_pkg::ram_count_width-1:0] count;
    logic                                busy;
    logic                                fire;

    // doubleword index from address bits 11 to 3
    assign word_index       = tbus_index[lsu_pkg::ram_index_width+2:3];
    assign tbus_index_ready = !busy;
    assign fire             = tbus_index_valid && tbus_index_ready;

    initial begin
        for (int i = 0; i < lsu_pkg::ram_words; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clock) begin
        if (fire && tbus_operation_type == lsu_pkg::tbus_write) begin
            mem[word_index] <= (mem[word_index] & ~tbus_write_mask)
                             | (tbus_write_data & tbus_write_mask);
        end
    end

    // old word is captured on a write too, the bus stage ignores it
    always_ff @(posedge clock) begin
        if (fire) begin
            tbus_read_data <= mem[word_index];
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy                <= 1'b0;
            count               <= '0;
            tbus_operation_done <= 1'b0;
        end else begin
            tbus_operation_done <= 1'b0;
            if (fire) begin
                busy  <= 1'b1;
                count <= lsu_pkg::ram_count_width'(lsu_pkg::ram_latency - 1);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == 1) begin
                    busy                <= 1'b0;
                    tbus_operation_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/lsu_load_align.sv
`timescale 1ns/100ps

module lsu_load_align (
    input  logic [lsu_pkg::xlen-1:0] tbus_read_data,
    input  logic [2:0]               offset,
    input  lsu_pkg::ls_size_t        ls_size,
    input  logic                     is_unsigned,
    output logic [lsu_pkg::xlen-1:0] load_data
);

    logic [lsu_pkg::xlen-1:0] byte_field;
    logic [lsu_pkg::xlen-1:0] half_field;
    logic [lsu_pkg::xlen-1:0] word_field;

    // each field is taken at its naturally aligned position
    assign byte_field = tbus_read_data >> {offset, 3'b000};
    assign half_field = tbus_read_data >> {offset[2:1], 4'b0000};
    assign word_field = tbus_read_data >> {offset[2], 5'b00000};

    always_comb begin
        case (ls_size)
            lsu_pkg::size_b: begin
                load_data = {{56{byte_field[7] && !is_unsigned}}, byte_field[7:0]};
            end
            lsu_pkg::size_h: begin
                load_data = {{48{half_field[15] && !is_unsigned}}, half_field[15:0]};
            end
            lsu_pkg::size_w: begin
                load_data = {{32{word_field[31] && !is_unsigned}}, word_field[31:0]};
            end
            default:         load_data = tbus_read_data;
        endcase
    end

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    localparam int xlen            = 64;
    localparam int id_width        = 8;
    localparam int preg_width      = 7;
    localparam int ram_words       = 512;
    localparam int ram_latency     = 2;
    localparam int ram_index_width = $clog2(ram_words);
    localparam int ram_count_width = $clog2(ram_latency + 1);

    // mmio window, both bounds inclusive
    localparam logic [xlen-1:0] mmio_low  = 64'h0000_0000_3000_0000;
    localparam logic [xlen-1:0] mmio_high = 64'h0000_0000_4070_0000;

    // one-hot access size
    typedef logic [3:0] ls_size_t;
    localparam ls_size_t size_b = 4'b0001;
    localparam ls_size_t size_h = 4'b0010;
    localparam ls_size_t size_w = 4'b0100;
    localparam ls_size_t size_d = 4'b1000;

    typedef enum logic {
        tbus_read  = 1'b0,
        tbus_write = 1'b1
    } tbus_op_t;

    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [preg_width-1:0] prd;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [xlen-1:0]       imm;
        logic                  is_load;
        logic                  is_store;
        logic                  is_unsigned;
        ls_size_t              ls_size;
    } issue_t;

    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [preg_width-1:0] prd;
        logic [xlen-1:0]       address;
        logic                  is_load;
        logic                  is_store;
        logic                  is_unsigned;
        ls_size_t              ls_size;
        logic                  mmio;
        logic [xlen-1:0]       write_data;
        logic [63:0]           write_mask;
    } mem_req_t;

    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [preg_width-1:0] prd;
        logic                  need_to_wb;
        logic                  mmio;
        logic [xlen-1:0]       data;
    } wb_t;

    // true when id a is older than id b, top bit is the wrap bit
    function automatic logic older_than(input logic [id_width-1:0] a,
                                        input logic [id_width-1:0] b);
        if (a[id_width-1] == b[id_width-1]) begin
            return a[id_width-2:0] < b[id_width-2:0];
        end
        return a[id_width-2:0] > b[id_width-2:0];
    endfunction

endpackage

// File: hdl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         instr_valid,
    input  lsu_pkg::issue_t              instr,
    output logic                         instr_ready,
    input  logic                         flush_valid,
    input  logic [lsu_pkg::id_width-1:0] flush_id,
    output logic                         wb_valid,
    output lsu_pkg::wb_t                 wb
);

    logic                     req_valid;
    logic                     req_ready;
    lsu_pkg::mem_req_t        req;
    logic                     tbus_index_valid;
    logic                     tbus_index_ready;
    logic [lsu_pkg::xlen-1:0] tbus_index;
    logic [lsu_pkg::xlen-1:0] tbus_write_data;
    logic [63:0]              tbus_write_mask;
    lsu_pkg::tbus_op_t        tbus_operation_type;
    logic [lsu_pkg::xlen-1:0] tbus_read_data;
    logic                     tbus_operation_done;

    lsu_addr_stage u_addr_stage (
        .clock       (clock),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush_valid (flush_valid),
        .flush_id    (flush_id),
        .req_ready   (req_ready),
        .instr_ready (instr_ready),
        .req_valid   (req_valid),
        .req         (req)
    );

    lsu_bus_stage u_bus_stage (
        .clock               (clock),
        .reset_n             (reset_n),
        .req_valid           (req_valid),
        .req                 (req),
        .flush_valid         (flush_valid),
        .flush_id            (flush_id),
        .tbus_index_ready    (tbus_index_ready),
        .tbus_read_data      (tbus_read_data),
        .tbus_operation_done (tbus_operation_done),
        .req_ready           (req_ready),
        .tbus_index_valid    (tbus_index_valid),
        .tbus_index          (tbus_index),
        .tbus_write_data     (tbus_write_data),
        .tbus_write_mask     (tbus_write_mask),
        .tbus_operation_type (tbus_operation_type),
        .wb_valid            (wb_valid),
        .wb                  (wb)
    );

    lsu_data_ram u_data_ram (
        .clock               (clock),
        .reset_n             (reset_n),
        .tbus_index_valid    (tbus_index_valid),
        .tbus_index          (tbus_index),
        .tbus_write_data     (tbus_write_data),
        .tbus_write_mask     (tbus_write_mask),
        .tbus_operation_type (tbus_operation_type),
        .tbus_index_ready    (tbus_index_ready),
        .tbus_read_data      (tbus_read_data),
        .tbus_operation_done (tbus_operation_done)
    );

endmodule

// File: sim.f
hdl/lsu_pkg.sv
hdl/lsu_load_align.sv
hdl/lsu_addr_stage.sv
hdl/lsu_bus_stage.sv
hdl/lsu_data_ram.sv
hdl/lsu_top.sv
bench/lsu_properties.sv
bench/lsu_tb.sv
